//--- source/rx_pcs_pkg.sv
package rx_pcs_pkg;

  //////////////////////////////
  // Line code geometry
  //////////////////////////////

  localparam int block_width = 66, payload_width = 64, header_width = 2;

  // Self-synchronous descrambler, 1 + x^39 + x^58
  localparam int scr_len = 58;

  localparam logic [1:0] sync_data = 2'b01, sync_ctrl = 2'b10;

  typedef enum logic [2:0] {
    bt_idle, bt_start, bt_data, bt_term, bt_error
  } block_type_e;

  // Control block type bytes, payload byte 0 after descrambling
  localparam logic [7:0] type_idle = 8'h1e, type_start = 8'h78;
  localparam logic [7:0] type_t0 = 8'h87, type_t1 = 8'h99, type_t2 = 8'haa, type_t3 = 8'hb4;
  localparam logic [7:0] type_t4 = 8'hcc, type_t5 = 8'hd2, type_t6 = 8'he1, type_t7 = 8'hff;

  //////////////////////////////
  // Ethernet CRC-32
  //////////////////////////////

  localparam logic [31:0] crc_poly    = 32'hedb88320;
  localparam logic [31:0] crc_residue = 32'hdebb20e3;

  //////////////////////////////
  // Stage structs
  //////////////////////////////

  typedef struct packed {
    logic                    valid;
    logic [header_width-1:0]  header;
    logic [payload_width-1:0] payload;
  } rx_block_t;

  typedef struct packed {
    logic                     valid;
    block_type_e              kind;
    logic [2:0]               term_bytes;
    logic [payload_width-1:0] payload;
  } decoded_block_t;

  typedef struct packed {
    logic                     valid;
    logic                     sop;
    logic                     eop;
    logic                     error;
    logic [7:0]               byte_mask;
    logic [payload_width-1:0] data;
  } frame_beat_t;

endpackage

//--- source/rx_block_decode.sv
`timescale 1ns/1ps

module rx_block_decode import rx_pcs_pkg::*; (
  input  logic           clk_156,
  input  logic           async_reset_n,
  input  rx_block_t      block_in,
  output decoded_block_t decoded
);

  // Block as seen on the line, first transmitted bit in bit 0
  logic [block_width-1:0]   line_bits;
  logic [header_width-1:0]  sync_hdr;
  logic [payload_width-1:0] scr_payload;
  logic [payload_width-1:0] clear_payload;
  logic [scr_len-1:0]       scr_state_q;
  logic [scr_len-1:0]       scr_next;
  block_type_e              kind_next;
  logic [2:0]               term_next;

  logic                     valid_q;
  block_type_e              kind_q;
  logic [2:0]               term_q;
  logic [payload_width-1:0] payload_q;

  assign line_bits   = {block_in.payload, block_in.header};
  assign sync_hdr    = line_bits[header_width-1:0];
  assign scr_payload = line_bits[block_width-1:header_width];

  //////////////////////////////
  // Descrambler
  //////////////////////////////

  // Bit 0 of the state is the most recent received bit
  always_comb begin
    scr_next = scr_state_q;
    for (int i = 0; i < payload_width; i++) begin
      clear_payload[i] = scr_payload[i] ^ scr_next[38] ^ scr_next[scr_len-1];
      scr_next = {scr_next[scr_len-2:0], scr_payload[i]};
    end
  end

  //////////////////////////////
  // Classifier
  //////////////////////////////

  always_comb begin
    kind_next = bt_error;
    if (sync_hdr == sync_data) begin
      kind_next = bt_data;
    end else if (sync_hdr == sync_ctrl) begin
      case (clear_payload[7:0])
        type_idle:  kind_next = bt_idle;
        type_start: kind_next = bt_start;
        type_t0, type_t1, type_t2, type_t3,
        type_t4, type_t5, type_t6, type_t7: kind_next = bt_term;
        default:    kind_next = bt_error;
      endcase
    end
  end

  // Number of data bytes carried by a terminate block
  always_comb begin
    case (clear_payload[7:0])
      type_t1: term_next = 3'd1;
      type_t2: term_next = 3'd2;
      type_t3: term_next = 3'd3;
      type_t4: term_next = 3'd4;
      type_t5: term_next = 3'd5;
      type_t6: term_next = 3'd6;
      type_t7: term_next = 3'd7;
      default: term_next = 3'd0;
    endcase
  end

  always_ff @(posedge clk_156 or negedge async_reset_n) begin
    if (!async_reset_n) begin
      scr_state_q <= '0;
      valid_q     <= 1'b0;
      kind_q      <= bt_idle;
      term_q      <= 3'd0;
    end else begin
      valid_q <= block_in.valid;
      if (block_in.valid) begin
        scr_state_q <= scr_next;
        kind_q      <= kind_next;
        term_q      <= term_next;
      end
    end
  end

  always_ff @(posedge clk_156) begin
    if (block_in.valid) begin
      payload_q <= clear_payload;
    end
  end

  assign decoded = '{valid: valid_q, kind: kind_q, term_bytes: term_q, payload: payload_q};

endmodule

//--- source/rx_frame_assemble.sv
`timescale 1ns/1ps

module rx_frame_assemble import rx_pcs_pkg::*; (
  input  logic           clk_156,
  input  logic           async_reset_n,
  input  decoded_block_t decoded,
  output frame_beat_t    beat
);

  typedef enum logic {
    st_idle,
    st_in_frame
  } frame_state_e;

  frame_state_e             state_q;
  frame_state_e             state_next;
  frame_beat_t              beat_next;
  logic [7:0]               term_mask;

  logic                     valid_q;
  logic                     sop_q;
  logic                     eop_q;
  logic                     error_q;
  logic [7:0]               mask_q;
  logic [payload_width-1:0] data_q;

  // Bytes 1 to k of a Tk block, empty for T0
  assign term_mask = 8'(((8'h01 << decoded.term_bytes) - 8'h01) << 1);

  //////////////////////////////
  // Framing FSM
  //////////////////////////////

  always_comb begin
    state_next     = state_q;
    beat_next      = '0;
    beat_next.data = decoded.payload;
    if (decoded.valid) begin
      case (state_q)
        st_idle: begin
          // Anything but start is dropped between frames
          if (decoded.kind == bt_start) begin
            beat_next.valid     = 1'b1;
            beat_next.sop       = 1'b1;
            beat_next.byte_mask = 8'hfe;
            state_next          = st_in_frame;
          end
        end
        st_in_frame: begin
          beat_next.valid = 1'b1;
          case (decoded.kind)
            bt_data: begin
              beat_next.byte_mask = 8'hff;
            end
            bt_term: begin
              beat_next.eop       = 1'b1;
              beat_next.byte_mask = term_mask;
              state_next          = st_idle;
            end
            default: begin
              // Idle, error or a second start aborts the frame
              beat_next.eop   = 1'b1;
              beat_next.error = 1'b1;
              state_next      = st_idle;
            end
          endcase
        end
        default: state_next = st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_156 or negedge async_reset_n) begin
    if (!async_reset_n) begin
      state_q <= st_idle;
      valid_q <= 1'b0;
      sop_q   <= 1'b0;
      eop_q   <= 1'b0;
      error_q <= 1'b0;
    end else begin
      state_q <= state_next;
      valid_q <= beat_next.valid;
      sop_q   <= beat_next.sop;
      eop_q   <= beat_next.eop;
      error_q <= beat_next.error;
    end
  end

  always_ff @(posedge clk_156) begin
    mask_q <= beat_next.byte_mask;
    data_q <= beat_next.data;
  end

  assign beat = '{valid: valid_q, sop: sop_q, eop: eop_q, error: error_q,
                  byte_mask: mask_q, data: data_q};

endmodule

//--- source/rx_crc_check.sv
`timescale 1ns/1ps

module rx_crc_check import rx_pcs_pkg::*; (
  input  logic        clk_156,
  input  logic        async_reset_n,
  input  frame_beat_t beat_in,
  output frame_beat_t beat_out,
  output logic        crc_ok
);

  logic [31:0]              crc_q;
  logic [31:0]              crc_next;
  logic                     crc_ok_q;

  logic                     valid_q;
  logic                     sop_q;
  logic                     eop_q;
  logic                     error_q;
  logic [7:0]               mask_q;
  logic [payload_width-1:0] data_q;

  // One byte of reflected CRC-32, LSB first
  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    c = crc ^ {24'h0, data};
    for (int b = 0; b < 8; b++) begin
      c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
    end
    return c;
  endfunction

  //////////////////////////////
  // Running CRC over masked bytes
  //////////////////////////////

  always_comb begin
    crc_next = beat_in.sop ? 32'hffffffff : crc_q;
    for (int i = 0; i < 8; i++) begin
      if (beat_in.byte_mask[i]) begin
        crc_next = crc_byte(crc_next, beat_in.data[8*i +: 8]);
      end
    end
  end

  always_ff @(posedge clk_156 or negedge async_reset_n) begin
    if (!async_reset_n) begin
      crc_q    <= 32'hffffffff;
      crc_ok_q <= 1'b0;
      valid_q  <= 1'b0;
      sop_q    <= 1'b0;
      eop_q    <= 1'b0;
      error_q  <= 1'b0;
    end else begin
      if (beat_in.valid) begin
        crc_q <= crc_next;
      end
      crc_ok_q <= beat_in.valid && beat_in.eop && !beat_in.error && (crc_next == crc_residue);
      valid_q  <= beat_in.valid;
      sop_q    <= beat_in.sop;
      eop_q    <= beat_in.eop;
      error_q  <= beat_in.error;
    end
  end

  always_ff @(posedge clk_156) begin
    mask_q <= beat_in.byte_mask;
    data_q <= beat_in.data;
  end

  assign beat_out = '{valid: valid_q, sop: sop_q, eop: eop_q, error: error_q,
                      byte_mask: mask_q, data: data_q};
  assign crc_ok   = crc_ok_q;

endmodule

//--- source/rx_pcs_lane.sv
`timescale 1ns/1ps

module rx_pcs_lane import rx_pcs_pkg::*; (
  input  logic        clk_156,
  input  logic        async_reset_n,
  input  rx_block_t   block_in,
  output frame_beat_t frame_out,
  output logic        crc_ok
);

  decoded_block_t decoded;
  frame_beat_t    beat;

  //////////////////////////////
  // Descramble and classify
  //////////////////////////////

  rx_block_decode u_block_decode (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .block_in      (block_in),
    .decoded       (decoded)
  );

  // Frame beats with byte mask
  rx_frame_assemble u_frame_assemble (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .decoded       (decoded),
    .beat          (beat)
  );

  // FCS check on eop
  rx_crc_check u_crc_check (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .beat_in       (beat),
    .beat_out      (frame_out),
    .crc_ok        (crc_ok)
  );

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_156,
  output logic async_reset_n
);

  // 4 ns period
  initial begin
    clk_156 = 1'b0;
    forever #2 clk_156 = ~clk_156;
  end

  // Reset edge lands after time zero so every flop sees it
  initial begin
    async_reset_n = 1'b1;
    #1 async_reset_n = 1'b0;
    repeat (10) @(posedge clk_156);
    async_reset_n <= 1'b1;
  end

endmodule

//--- bench/rx_pcs_lane_sva.sv
`timescale 1ns/1ps

module rx_pcs_lane_sva import rx_pcs_pkg::*; (
  input logic        clk_156,
  input logic        async_reset_n,
  input frame_beat_t frame_out,
  input logic        crc_ok
);

  // Frame markers only ride on valid beats
  sop_needs_valid: assert property (@(posedge clk_156) disable iff (!async_reset_n)
    frame_out.sop |-> frame_out.valid) else $error("sop without valid");

  eop_needs_valid: assert property (@(posedge clk_156) disable iff (!async_reset_n)
    frame_out.eop |-> frame_out.valid) else $error("eop without valid");

  crc_ok_needs_eop: assert property (@(posedge clk_156) disable iff (!async_reset_n)
    crc_ok |-> frame_out.eop) else $error("crc_ok outside an eop beat");

  // Outputs held clear in reset
  quiet_in_reset: assert property (@(posedge clk_156) !async_reset_n |->
    !(frame_out.valid || frame_out.sop || frame_out.eop || frame_out.error || crc_ok))
    else $error("output active during reset");

endmodule

bind rx_pcs_lane rx_pcs_lane_sva lane_checks (
  .clk_156       (clk_156),
  .async_reset_n (async_reset_n),
  .frame_out     (frame_out),
  .crc_ok        (crc_ok)
);

//--- bench/rx_pcs_lane_tb.sv
`timescale 1ns/1ps

module rx_pcs_lane_tb import rx_pcs_pkg::*; ();

  typedef enum logic [1:0] {ins_none, ins_idle, ins_bad_header} insert_e;

  // Payload length, corrupt FCS, block before terminate, expected crc_ok
  typedef struct packed {
    logic [7:0] length;
    logic       corrupt;
    insert_e    insert;
    logic       expect_ok;
  } frame_entry_t;

  typedef struct packed {
    frame_beat_t beat;
    logic        crc_ok;
  } expect_t;

  logic        clk_156;
  logic        async_reset_n;
  rx_block_t   block_in;
  frame_beat_t frame_out;
  logic        crc_ok;

  integer      seed = 32'haa89;
  logic [57:0] tx_scr = '0;
  expect_t     pending [$];
  logic        eop_seen = 1'b0;

  frame_entry_t frame_table [34] = '{
    '{8'd4,1'b0,ins_none,1'b1}, '{8'd5,1'b0,ins_none,1'b1}, '{8'd6,1'b0,ins_none,1'b1},
    '{8'd7,1'b0,ins_none,1'b1}, '{8'd8,1'b0,ins_none,1'b1}, '{8'd9,1'b0,ins_none,1'b1},
    '{8'd10,1'b0,ins_none,1'b1}, '{8'd11,1'b0,ins_none,1'b1}, '{8'd12,1'b0,ins_none,1'b1},
    '{8'd13,1'b0,ins_none,1'b1}, '{8'd14,1'b0,ins_none,1'b1}, '{8'd15,1'b0,ins_none,1'b1},
    '{8'd16,1'b0,ins_none,1'b1}, '{8'd17,1'b0,ins_none,1'b1}, '{8'd18,1'b0,ins_none,1'b1},
    '{8'd19,1'b0,ins_none,1'b1}, '{8'd20,1'b0,ins_none,1'b1}, '{8'd21,1'b0,ins_none,1'b1},
    '{8'd22,1'b0,ins_none,1'b1}, '{8'd23,1'b0,ins_none,1'b1}, '{8'd24,1'b0,ins_none,1'b1},
    '{8'd25,1'b0,ins_none,1'b1}, '{8'd26,1'b0,ins_none,1'b1}, '{8'd27,1'b0,ins_none,1'b1},
    '{8'd28,1'b0,ins_none,1'b1}, '{8'd29,1'b0,ins_none,1'b1}, '{8'd30,1'b0,ins_none,1'b1},
    '{8'd12,1'b1,ins_none,1'b0}, '{8'd25,1'b1,ins_none,1'b0}, '{8'd16,1'b0,ins_idle,1'b0},
    '{8'd9,1'b0,ins_bad_header,1'b0}, '{8'd30,1'b0,ins_idle,1'b0},
    '{8'd21,1'b0,ins_bad_header,1'b0}, '{8'd5,1'b0,ins_none,1'b1}
  };

  tb_clock_gen clock_gen (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n)
  );

  rx_pcs_lane dut (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .block_in      (block_in),
    .frame_out     (frame_out),
    .crc_ok        (crc_ok)
  );

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("Error at %0t: %s is %0h, expected %0h",
                               $time, name, actual, expected));
    end
  endtask

  function automatic logic [63:0] byte_lanes(input logic [7:0] mask);
    logic [63:0] lanes;
    for (int b = 0; b < 8; b++) begin
      lanes[8*b +: 8] = {8{mask[b]}};
    end
    return lanes;
  endfunction

  // Bit-serial Ethernet CRC, preset to ones, no final inversion
  function automatic logic [31:0] fcs_model(input logic [7:0] data [$]);
    logic [31:0] crc;
    logic        fb;
    crc = 32'hffffffff;
    foreach (data[n]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ data[n][b];
        crc = crc >> 1;
        if (fb) crc = crc ^ crc_poly;
      end
    end
    return crc;
  endfunction

  function automatic logic [7:0] term_type(input int k);
    case (k)
      0: return type_t0;
      1: return type_t1;
      2: return type_t2;
      3: return type_t3;
      4: return type_t4;
      5: return type_t5;
      6: return type_t6;
      default: return type_t7;
    endcase
  endfunction

  function automatic expect_t expect_beat(input logic sop, input logic eop, input logic error,
                                          input logic [7:0] mask, input logic [63:0] data,
                                          input logic ok);
    return '{beat: '{valid: 1'b1, sop: sop, eop: eop, error: error, byte_mask: mask,
                     data: data}, crc_ok: ok};
  endfunction

  // Transmit scrambler, 1 + x^39 + x^58
  task automatic scramble(input logic [63:0] clear, output logic [63:0] line);
    logic fb;
    for (int i = 0; i < 64; i++) begin
      fb      = clear[i] ^ tx_scr[38] ^ tx_scr[57];
      line[i] = fb;
      tx_scr  = {tx_scr[56:0], fb};
    end
  endtask

  task automatic compare_output(input expect_t e);
    logic [63:0] lanes;
    lanes = byte_lanes(e.beat.byte_mask);
    check_value("frame_out.valid", 64'(frame_out.valid), 64'(e.beat.valid));
    if (e.beat.valid) begin
      check_value("frame_out.sop", 64'(frame_out.sop), 64'(e.beat.sop));
      check_value("frame_out.eop", 64'(frame_out.eop), 64'(e.beat.eop));
      check_value("frame_out.error", 64'(frame_out.error), 64'(e.beat.error));
      check_value("frame_out.byte_mask", 64'(frame_out.byte_mask), 64'(e.beat.byte_mask));
      check_value("frame_out.data", frame_out.data & lanes, e.beat.data & lanes);
      if (e.beat.eop) begin
        check_value("crc_ok", 64'(crc_ok), 64'(e.crc_ok));
        eop_seen = 1'b1;
      end
    end
  endtask

  // Output at each falling edge belongs to the block driven three cycles earlier
  task automatic drive_cycle(input rx_block_t blk, input expect_t e);
    expect_t due;
    @(posedge clk_156);
    block_in <= blk;
    pending.push_back(e);
    @(negedge clk_156);
    due = pending.pop_front();
    compare_output(due);
  endtask

  task automatic send_block(input logic [1:0] header, input logic [63:0] clear,
                            input expect_t e);
    logic [63:0] line;
    rx_block_t   blk;
    scramble(clear, line);
    blk = '{valid: 1'b1, header: header, payload: line};
    drive_cycle(blk, e);
  endtask

  task automatic send_frame(input frame_entry_t ent);
    logic [7:0]  bytes [$];
    logic [31:0] fcs;
    logic [63:0] word;
    logic [7:0]  mask;
    int          len;
    int          pos;
    int          k;
    int          wait_cycles;
    logic        aborted;

    len = int'(ent.length);
    for (int i = 0; i < len; i++) bytes.push_back(8'($random(seed)));
    fcs = ~fcs_model(bytes);
    for (int i = 0; i < 4; i++) bytes.push_back(fcs[8*i +: 8]);
    if (ent.corrupt) bytes[len] = bytes[len] ^ 8'h10;
    eop_seen = 1'b0;
    aborted  = 1'b0;

    // Start block carries frame bytes 0 to 6 in lanes 1 to 7
    word = {56'h0, type_start};
    for (int b = 1; b < 8; b++) word[8*b +: 8] = bytes[b-1];
    send_block(sync_ctrl, word, expect_beat(1'b1, 1'b0, 1'b0, 8'hfe, word, 1'b0));
    pos = 7;
    while (len + 4 - pos >= 8) begin
      for (int b = 0; b < 8; b++) word[8*b +: 8] = bytes[pos+b];
      send_block(sync_data, word, expect_beat(1'b0, 1'b0, 1'b0, 8'hff, word, 1'b0));
      pos += 8;
    end

    if (ent.insert == ins_idle) begin
      word = {56'h0, type_idle};
      send_block(sync_ctrl, word, expect_beat(1'b0, 1'b1, 1'b1, 8'h00, word, 1'b0));
      aborted = 1'b1;
    end else if (ent.insert == ins_bad_header) begin
      word = {32'($random(seed)), 32'($random(seed))};
      send_block(2'b11, word, expect_beat(1'b0, 1'b1, 1'b1, 8'h00, word, 1'b0));
      aborted = 1'b1;
    end

    // Terminate Tk, dropped once the frame is aborted
    k    = len + 4 - pos;
    word = {56'h0, term_type(k)};
    mask = 8'h00;
    for (int b = 1; b <= k; b++) begin
      word[8*b +: 8] = bytes[pos+b-1];
      mask[b]        = 1'b1;
    end
    if (aborted) send_block(sync_ctrl, word, '0);
    else send_block(sync_ctrl, word, expect_beat(1'b0, 1'b1, 1'b0, mask, word, ent.expect_ok));

    wait_cycles = 0;
    while (!eop_seen) begin
      send_block(sync_ctrl, {56'h0, type_idle}, '0);
      wait_cycles++;
      if (wait_cycles > 8) report_failure("Timeout waiting for the eop beat of a frame");
    end
    // Stray data block and an empty cycle between frames
    send_block(sync_data, {32'($random(seed)), 32'($random(seed))}, '0);
    drive_cycle('0, '0);
  endtask

  initial begin
    int wait_cycles;
    block_in    = '0;
    wait_cycles = 0;
    do begin
      @(posedge clk_156);
      wait_cycles++;
      if (wait_cycles > 40) report_failure("Timeout waiting for reset release");
    end while (!async_reset_n);

    repeat (3) pending.push_back('0);
    foreach (frame_table[n]) send_frame(frame_table[n]);
    repeat (3) drive_cycle('0, '0);

    $display("No errors");
    $finish;
  end

endmodule

//--- vlog.f
source/rx_pcs_pkg.sv
source/rx_block_decode.sv
source/rx_frame_assemble.sv
source/rx_crc_check.sv
source/rx_pcs_lane.sv
bench/tb_clock_gen.sv
bench/rx_pcs_lane_sva.sv
bench/rx_pcs_lane_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rx_pcs_lane_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
